// File: flist.f
rtl/corr_sizes_pkg.sv
rtl/corr_ctrl_pkg.sv
rtl/command_decoder.sv
rtl/sample_delay_line.sv
rtl/lag_accumulator.sv
rtl/spectrum_readout.sv
rtl/autocorrelator_top.sv
verif/autocorrelator_tb.sv

// File: rtl/autocorrelator_top.sv
// Top level of the multi-channel autocorrelator; sets the sizes and wires decoder, channels and readout.

`timescale 1ns/1ns

module autocorrelator_top #(
	parameter int num_inputs   = corr_sizes_pkg::default_num_inputs,
	parameter int num_lags     = corr_sizes_pkg::default_num_lags,
	parameter int sample_width = corr_sizes_pkg::default_sample_width,
	parameter int acc_width    = corr_sizes_pkg::default_acc_width,
	parameter int max_offset   = corr_sizes_pkg::default_max_offset,
	localparam int offset_width = (max_offset > 0) ? $clog2(max_offset + 1) : 1,
	localparam int line_width   = (num_inputs > 1) ? $clog2(num_inputs) : 1,
	localparam int arg_width    = offset_width + 1
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               cmd_strobe,
	input  corr_ctrl_pkg::corr_op_t            cmd_op,
	input  logic [line_width-1:0]              cmd_line,
	input  logic [arg_width-1:0]               cmd_arg,
	input  logic [num_inputs-1:0]              smp_strobe,
	input  logic [num_inputs*sample_width-1:0] smp_data,
	output logic                               cmd_error,
	output logic                               running,
	output logic                               rd_valid,
	output logic signed [acc_width-1:0]        rd_data,
	output logic                               rd_sat,
	output logic                               rd_last
);

	localparam int depth = max_offset + num_lags;

	logic [num_inputs*offset_width-1:0]        tap_offset;
	logic [num_inputs-1:0]                     mode;
	logic                                      clear_pulse;
	logic                                      readout_pulse;
	logic [depth*sample_width-1:0]             history [num_inputs];
	logic [num_inputs*num_lags*acc_width-1:0]  acc_all;
	logic [num_inputs-1:0]                     sat_all;

	command_decoder #(
		.num_inputs(num_inputs),
		.max_offset(max_offset),
		.offset_width(offset_width),
		.line_width(line_width),
		.arg_width(arg_width)
	) u_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_strobe(cmd_strobe),
		.cmd_op(cmd_op),
		.cmd_line(cmd_line),
		.cmd_arg(cmd_arg),
		.tap_offset(tap_offset),
		.mode(mode),
		.run(running),
		.clear_pulse(clear_pulse),
		.readout_pulse(readout_pulse),
		.cmd_error(cmd_error)
	);

	genvar i;
	for (i = 0; i < num_inputs; i++) begin : g_channel
		sample_delay_line #(
			.sample_width(sample_width),
			.depth(depth)
		) u_delay (
			.clk(clk),
			.rst_n(rst_n),
			.smp_strobe(smp_strobe[i]),
			.smp_in(smp_data[i*sample_width +: sample_width]),
			.history(history[i])
		);

		lag_accumulator #(
			.num_lags(num_lags),
			.sample_width(sample_width),
			.acc_width(acc_width),
			.max_offset(max_offset),
			.offset_width(offset_width)
		) u_acc (
			.clk(clk),
			.rst_n(rst_n),
			.smp_strobe(smp_strobe[i]),
			.smp_in(smp_data[i*sample_width +: sample_width]),
			.history(history[i]),
			.tap_offset(tap_offset[i*offset_width +: offset_width]),
			.mode(corr_ctrl_pkg::corr_mode_t'(mode[i])),
			.run(running),
			.clear_pulse(clear_pulse),
			.acc_vec(acc_all[i*num_lags*acc_width +: num_lags*acc_width]),
			.sat(sat_all[i])
		);
	end

	spectrum_readout #(
		.num_inputs(num_inputs),
		.num_lags(num_lags),
		.acc_width(acc_width)
	) u_readout (
		.clk(clk),
		.rst_n(rst_n),
		.acc_all(acc_all),
		.sat_all(sat_all),
		.readout_pulse(readout_pulse),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_sat(rd_sat),
		.rd_last(rd_last)
	);

endmodule

// File: rtl/command_decoder.sv
// Command decoder that holds per-channel offset and mode registers and drives run, clear and readout.

`timescale 1ns/1ns

module command_decoder #(
	parameter int num_inputs   = corr_sizes_pkg::default_num_inputs,
	parameter int max_offset   = corr_sizes_pkg::default_max_offset,
	parameter int offset_width = corr_sizes_pkg::offset_width,
	parameter int line_width   = $clog2(corr_sizes_pkg::default_num_inputs),
	parameter int arg_width    = corr_sizes_pkg::offset_width + 1
) (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               cmd_strobe,
	input  corr_ctrl_pkg::corr_op_t            cmd_op,
	input  logic [line_width-1:0]              cmd_line,
	input  logic [arg_width-1:0]               cmd_arg,
	output logic [num_inputs*offset_width-1:0] tap_offset,
	output logic [num_inputs-1:0]              mode,
	output logic                               run,
	output logic                               clear_pulse,
	output logic                               readout_pulse,
	output logic                               cmd_error
);

	logic offset_bad;

	assign offset_bad = (cmd_arg > max_offset);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tap_offset    <= '0;
			mode          <= '0; // All channels start in product mode.
			run           <= 1'b0;
			clear_pulse   <= 1'b0;
			readout_pulse <= 1'b0;
			cmd_error     <= 1'b0;
		end else begin
			clear_pulse   <= 1'b0;
			readout_pulse <= 1'b0;
			cmd_error     <= 1'b0;
			if (cmd_strobe) begin
				case (cmd_op)
					corr_ctrl_pkg::op_nop: begin
					end
					corr_ctrl_pkg::op_set_offset: begin
						if (offset_bad) begin
							cmd_error <= 1'b1; // The offset register keeps its value.
						end else begin
							tap_offset[cmd_line*offset_width +: offset_width] <=
								cmd_arg[offset_width-1:0];
						end
					end
					corr_ctrl_pkg::op_set_mode: begin
						mode[cmd_line] <= cmd_arg[0];
					end
					corr_ctrl_pkg::op_run: begin
						run <= 1'b1;
					end
					corr_ctrl_pkg::op_halt: begin
						run <= 1'b0;
					end
					corr_ctrl_pkg::op_clear: begin
						clear_pulse <= 1'b1;
					end
					corr_ctrl_pkg::op_readout: begin
						readout_pulse <= 1'b1; // The readout ignores it while streaming.
					end
					default: begin
						cmd_error <= 1'b1;
					end
				endcase
			end
		end
	end

	// Commands must address an existing channel, or the register write is lost.
	a_line_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		cmd_strobe |-> (cmd_line < num_inputs)
	) else $error("Command addresses channel %0d of %0d.", cmd_line, num_inputs);

endmodule

// File: rtl/corr_ctrl_pkg.sv
// Opcode, correlation mode and readout state encodings used by the command port and the readout.

package corr_ctrl_pkg;

	// Command opcodes. The value 7 is not assigned and is reported as an error.
	typedef enum logic [2:0] {
		op_nop        = 3'd0,
		op_set_offset = 3'd1, // cmd_arg holds the new tap offset.
		op_set_mode   = 3'd2, // cmd_arg[0] holds the new mode.
		op_run        = 3'd3,
		op_halt       = 3'd4,
		op_clear      = 3'd5,
		op_readout    = 3'd6
	} corr_op_t;

	// Per-channel correlation mode.
	typedef enum logic {
		mode_product    = 1'b0, // Accumulate x times h.
		mode_difference = 1'b1  // Accumulate x minus h.
	} corr_mode_t;

	// Readout engine states.
	typedef enum logic {
		ro_idle   = 1'b0,
		ro_stream = 1'b1
	} readout_state_t;

endpackage

// File: rtl/corr_sizes_pkg.sv
// Default sizes of the autocorrelator and the width rules derived from them, for RTL and testbench.

package corr_sizes_pkg;

	// Number of input channels.
	parameter int default_num_inputs = 4;

	// Lags kept per channel.
	parameter int default_num_lags = 4;

	// Signed sample width in bits.
	parameter int default_sample_width = 4;

	// Signed accumulator width in bits.
	parameter int default_acc_width = 16;

	// Largest tap offset a channel may be set to.
	parameter int default_max_offset = 3;

	// Bits needed to hold any offset from 0 to default_max_offset.
	// A command argument carries one more bit so that out of range offsets can be seen.
	parameter int offset_width =
		(default_max_offset > 0) ? $clog2(default_max_offset + 1) : 1;

endpackage

// File: rtl/lag_accumulator.sv
// Accumulates product or difference terms for every lag of one channel and freezes near full scale.

`timescale 1ns/1ns

module lag_accumulator #(
	parameter int num_lags     = corr_sizes_pkg::default_num_lags,
	parameter int sample_width = corr_sizes_pkg::default_sample_width,
	parameter int acc_width    = corr_sizes_pkg::default_acc_width,
	parameter int max_offset   = corr_sizes_pkg::default_max_offset,
	parameter int offset_width = corr_sizes_pkg::offset_width
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  smp_strobe,
	input  logic signed [sample_width-1:0]        smp_in,
	input  logic [(max_offset+num_lags)*sample_width-1:0] history,
	input  logic [offset_width-1:0]               tap_offset,
	input  corr_ctrl_pkg::corr_mode_t             mode,
	input  logic                                  run,
	input  logic                                  clear_pulse,
	output logic [num_lags*acc_width-1:0]         acc_vec,
	output logic                                  sat
);

	localparam int depth = max_offset + num_lags;

	// The margin below full scale is larger than any single term, so the add cannot wrap.
	localparam logic signed [acc_width-1:0] sat_limit =
		acc_width'((64'sd1 <<< (acc_width - 1)) - (64'sd1 <<< (2 * sample_width)));

	logic [(depth+1)*sample_width-1:0] taps;
	logic [num_lags-1:0]               frozen;

	// Tap 0 is the incoming sample itself, so lag 0 at offset 0 gives the signal power.
	assign taps = {history, smp_in};

	genvar k;
	for (k = 0; k < num_lags; k++) begin : g_lag
		logic signed [sample_width-1:0]   h;
		logic signed [2*sample_width-1:0] prod;
		logic signed [sample_width:0]     diff;
		logic signed [acc_width-1:0]      term;
		logic signed [acc_width-1:0]      acc;

		assign h    = taps[(tap_offset + k) * sample_width +: sample_width];
		assign prod = smp_in * h;
		assign diff = smp_in - h;
		assign term = (mode == corr_ctrl_pkg::mode_difference) ?
			acc_width'(diff) : acc_width'(prod);

		assign frozen[k] = (acc >= sat_limit) || (acc <= -sat_limit);

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				acc <= '0;
			end else if (clear_pulse) begin
				acc <= '0;
			end else if (smp_strobe && run && !frozen[k]) begin
				acc <= acc + term; // History is still the one from before this strobe.
			end
		end

		assign acc_vec[k*acc_width +: acc_width] = acc;
	end

	// Sticky until the next clear, even though a frozen lag never moves again.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sat <= 1'b0;
		end else if (clear_pulse) begin
			sat <= 1'b0;
		end else if (|frozen) begin
			sat <= 1'b1;
		end
	end

	// The decoder must keep every offset inside the delay line.
	a_offset_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		tap_offset <= max_offset
	) else $error("Tap offset %0d exceeds %0d.", tap_offset, max_offset);

endmodule

// File: rtl/sample_delay_line.sv
// Per-channel history of past samples, shifted on the channel's sample strobe and exposed tap by tap.

`timescale 1ns/1ns

module sample_delay_line #(
	parameter int sample_width = corr_sizes_pkg::default_sample_width,
	parameter int depth        = corr_sizes_pkg::default_max_offset +
	                             corr_sizes_pkg::default_num_lags
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          smp_strobe,
	input  logic [sample_width-1:0]       smp_in,
	output logic [depth*sample_width-1:0] history
);

	// The lowest slot is tap 1, the sample before the one now arriving.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			history <= '0;
		end else if (smp_strobe) begin
			history[sample_width-1:0] <= smp_in;
			for (int j = 1; j < depth; j++) begin
				history[j*sample_width +: sample_width] <=
					history[(j-1)*sample_width +: sample_width];
			end
		end
	end

endmodule

// File: rtl/spectrum_readout.sv
// Readout engine that snapshots every accumulator and streams the words out one per cycle.

`timescale 1ns/1ns

module spectrum_readout #(
	parameter int num_inputs = corr_sizes_pkg::default_num_inputs,
	parameter int num_lags   = corr_sizes_pkg::default_num_lags,
	parameter int acc_width  = corr_sizes_pkg::default_acc_width
) (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [num_inputs*num_lags*acc_width-1:0] acc_all,
	input  logic [num_inputs-1:0]                  sat_all,
	input  logic                                   readout_pulse,
	output logic                                   rd_valid,
	output logic signed [acc_width-1:0]            rd_data,
	output logic                                   rd_sat,
	output logic                                   rd_last
);

	localparam int num_words = num_inputs * num_lags;
	localparam int idx_width = (num_words > 1) ? $clog2(num_words) : 1;
	localparam logic [idx_width-1:0] last_idx = idx_width'(num_words - 1);

	corr_ctrl_pkg::readout_state_t state;

	logic [idx_width-1:0]           idx;
	logic [num_words*acc_width-1:0] snap;
	logic [num_inputs-1:0]          sat_snap;
	logic                           start;

	assign start = (state == corr_ctrl_pkg::ro_idle) && readout_pulse;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= corr_ctrl_pkg::ro_idle;
			idx   <= '0;
		end else begin
			case (state)
				corr_ctrl_pkg::ro_idle: begin
					if (readout_pulse) begin
						state <= corr_ctrl_pkg::ro_stream;
						idx   <= '0;
					end
				end
				corr_ctrl_pkg::ro_stream: begin
					if (idx == last_idx) begin
						state <= corr_ctrl_pkg::ro_idle;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				default: begin
					state <= corr_ctrl_pkg::ro_idle;
				end
			endcase
		end
	end

	// Accumulation goes on while the stream runs from this copy.
	always_ff @(posedge clk) begin
		if (start) begin
			snap     <= acc_all;
			sat_snap <= sat_all;
		end
	end

	assign rd_valid = (state == corr_ctrl_pkg::ro_stream);
	assign rd_last  = (state == corr_ctrl_pkg::ro_stream) && (idx == last_idx);
	assign rd_data  = snap[idx*acc_width +: acc_width]; // Channel 0 lag 0 comes first.
	assign rd_sat   = sat_snap[idx / num_lags];

	// The first word is channel 0 lag 0 as it stood when the readout started.
	a_first_word: assert property (
		@(posedge clk) disable iff (!rst_n)
		start |=> rd_valid && (rd_data == $past(acc_all[acc_width-1:0]))
	) else $error("Readout did not open with the snapshot of channel 0 lag 0.");

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the autocorrelator testbench with Verilator, runs it and checks for the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f \
	--top-module autocorrelator_tb \
	-o autocorrelator_sim

output="$(./obj_dir/autocorrelator_sim)"
echo "$output"

if echo "$output" | grep -qF -- '** PASS **'; then
	exit 0
else
	exit 1
fi

// File: verif/autocorrelator_tb.sv
// Testbench for autocorrelator_top; drives commands and samples and checks every readout word.

`timescale 1ns/1ns

module autocorrelator_tb;

	localparam int num_inputs   = corr_sizes_pkg::default_num_inputs;
	localparam int num_lags     = corr_sizes_pkg::default_num_lags;
	localparam int sample_width = corr_sizes_pkg::default_sample_width;
	localparam int acc_width    = corr_sizes_pkg::default_acc_width;
	localparam int max_offset   = corr_sizes_pkg::default_max_offset;
	localparam int offset_width = corr_sizes_pkg::offset_width;
	localparam int line_width   = (num_inputs > 1) ? $clog2(num_inputs) : 1;
	localparam int arg_width    = offset_width + 1;
	localparam int depth        = max_offset + num_lags;
	localparam int num_words    = num_inputs * num_lags;

	// An accumulator stops moving once its magnitude reaches this value.
	localparam int sat_limit = (1 << (acc_width - 1)) - (1 << (2 * sample_width));
	localparam logic signed [sample_width-1:0] full_scale_sample =
		{1'b1, {(sample_width - 1){1'b0}}};

	localparam int clk_period     = 20;
	localparam int reset_cycles   = 10;
	localparam int rand_cycles    = 200;
	localparam int short_cycles   = 100;
	localparam int sat_cycles     = 600;
	localparam int extra_cycles   = 20;
	localparam int cmd_cycles     = 64; // Commands, idle cycles and reset release.
	localparam int num_readouts   = 10;
	localparam int stimulus_cycles = reset_cycles + 2 * rand_cycles + 3 * short_cycles +
		sat_cycles + extra_cycles + cmd_cycles;
	localparam int readout_cycles = num_readouts * (num_words + 16);
	localparam longint watchdog_ns =
		4 * longint'(stimulus_cycles + readout_cycles) * clk_period;

	logic                               clk = 1'b0;
	logic                               rst_n;
	logic                               cmd_strobe;
	corr_ctrl_pkg::corr_op_t            cmd_op;
	logic [line_width-1:0]              cmd_line;
	logic [arg_width-1:0]               cmd_arg;
	logic [num_inputs-1:0]              smp_strobe;
	logic [num_inputs*sample_width-1:0] smp_data;
	logic                               cmd_error;
	logic                               running;
	logic                               rd_valid;
	logic signed [acc_width-1:0]        rd_data;
	logic                               rd_sat;
	logic                               rd_last;

	// Reference model state.
	int m_hist [num_inputs][depth]; // Index 0 is tap 1, the previous sample.
	int m_acc  [num_inputs][num_lags];
	int m_off  [num_inputs];
	bit m_mode [num_inputs]; // 1 selects difference mode.
	bit m_sat  [num_inputs];
	bit m_run;

	integer seed;
	string  test_name;
	int     exp_data [$];
	bit     exp_sat [$];
	int     want_d;
	bit     want_s;
	int     word_cnt;
	int     readouts_done;
	int     cmp_errors;
	int     ctl_errors;

	autocorrelator_top #(
		.num_inputs(num_inputs),
		.num_lags(num_lags),
		.sample_width(sample_width),
		.acc_width(acc_width),
		.max_offset(max_offset)
	) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_strobe(cmd_strobe),
		.cmd_op(cmd_op),
		.cmd_line(cmd_line),
		.cmd_arg(cmd_arg),
		.smp_strobe(smp_strobe),
		.smp_data(smp_data),
		.cmd_error(cmd_error),
		.running(running),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.rd_sat(rd_sat),
		.rd_last(rd_last)
	);

	always #(clk_period / 2) clk = ~clk;

	function automatic void clear_model();
		for (int ch = 0; ch < num_inputs; ch++) begin
			for (int j = 0; j < depth; j++) begin
				m_hist[ch][j] = 0;
			end
			for (int k = 0; k < num_lags; k++) begin
				m_acc[ch][k] = 0;
			end
			m_off[ch]  = 0;
			m_mode[ch] = 1'b0;
			m_sat[ch]  = 1'b0;
		end
		m_run = 1'b0;
	endfunction

	// Reference rule for one sample x arriving on channel ch.
	function automatic void apply_strobe(int ch, int x);
		int h;
		int term;
		if (m_run) begin
			for (int k = 0; k < num_lags; k++) begin
				if (m_off[ch] + k == 0) begin
					h = x; // Tap 0 is the incoming sample.
				end else begin
					h = m_hist[ch][m_off[ch] + k - 1];
				end
				term = m_mode[ch] ? (x - h) : (x * h);
				if (m_acc[ch][k] < sat_limit && m_acc[ch][k] > -sat_limit) begin
					m_acc[ch][k] += term;
				end
				if (m_acc[ch][k] >= sat_limit || m_acc[ch][k] <= -sat_limit) begin
					m_sat[ch] = 1'b1;
				end
			end
		end
		for (int j = depth - 1; j > 0; j--) begin
			m_hist[ch][j] = m_hist[ch][j-1];
		end
		m_hist[ch][0] = x;
	endfunction

	function automatic int expected_word(int w);
		return m_acc[w / num_lags][w % num_lags];
	endfunction

	task automatic send_cmd(input corr_ctrl_pkg::corr_op_t op, input int line, input int arg,
			input bit expect_err);
		cmd_strobe = 1'b1;
		cmd_op     = op;
		cmd_line   = line_width'(line);
		cmd_arg    = arg_width'(arg);
		smp_strobe = '0;
		@(negedge clk);
		cmd_strobe = 1'b0;
		cmd_op     = corr_ctrl_pkg::op_nop;
		assert (cmd_error == expect_err) else begin
			ctl_errors++;
			$display("Fail %s cmd_error: expected %0d, actual %0d", test_name, expect_err,
				cmd_error);
		end
	endtask

	task automatic set_offset(input int ch, input int off);
		send_cmd(corr_ctrl_pkg::op_set_offset, ch, off, off > max_offset);
		if (off <= max_offset) begin
			m_off[ch] = off;
		end
	endtask

	task automatic set_mode(input int ch, input bit md);
		send_cmd(corr_ctrl_pkg::op_set_mode, ch, int'(md), 1'b0);
		m_mode[ch] = md;
	endtask

	task automatic set_run(input bit on);
		if (on) begin
			send_cmd(corr_ctrl_pkg::op_run, 0, 0, 1'b0);
		end else begin
			send_cmd(corr_ctrl_pkg::op_halt, 0, 0, 1'b0);
		end
		m_run = on;
		assert (running == on) else begin
			ctl_errors++;
			$display("Fail %s running: expected %0d, actual %0d", test_name, on, running);
		end
	endtask

	task automatic clear_accumulators();
		send_cmd(corr_ctrl_pkg::op_clear, 0, 0, 1'b0);
		for (int ch = 0; ch < num_inputs; ch++) begin
			for (int k = 0; k < num_lags; k++) begin
				m_acc[ch][k] = 0;
			end
			m_sat[ch] = 1'b0;
		end
		@(negedge clk); // The clear lands on the next edge.
	endtask

	task automatic drive_samples(input int cycles, input bit full_scale);
		logic signed [sample_width-1:0] s;
		logic [31:0]                    pick;
		logic [31:0]                    value;
		for (int c = 0; c < cycles; c++) begin
			pick  = $random(seed);
			value = $random(seed);
			for (int ch = 0; ch < num_inputs; ch++) begin
				s = full_scale ? full_scale_sample : value[ch*sample_width +: sample_width];
				smp_data[ch*sample_width +: sample_width] = s;
				smp_strobe[ch] = full_scale | pick[ch];
				if (smp_strobe[ch]) begin
					apply_strobe(ch, int'(s));
				end
			end
			@(negedge clk);
		end
		smp_strobe = '0;
	endtask

	// With busy set, a second readout and some samples are sent while the stream runs.
	task automatic check_readout(input string name, input bit busy);
		int done_before;
		int waited;
		test_name = name;
		for (int w = 0; w < num_words; w++) begin
			exp_data.push_back(expected_word(w));
			exp_sat.push_back(m_sat[w / num_lags]);
		end
		done_before = readouts_done;
		send_cmd(corr_ctrl_pkg::op_readout, 0, 0, 1'b0);
		if (busy) begin
			send_cmd(corr_ctrl_pkg::op_readout, 0, 0, 1'b0);
			drive_samples(8, 1'b0);
		end
		waited = 0;
		while (readouts_done == done_before && waited < num_words + 8) begin
			@(negedge clk);
			waited++;
		end
		assert (readouts_done != done_before) else begin
			ctl_errors++;
			$display("Readout for %s did not finish within %0d cycles.", name, waited);
		end
		repeat (2) @(negedge clk);
		assert (exp_data.size() == 0) else begin
			ctl_errors++;
			$display("Readout for %s left %0d words undelivered.", name, exp_data.size());
		end
		exp_data.delete();
		exp_sat.delete();
	endtask

	// Compares each streamed word against the queued expectation.
	always @(negedge clk) begin
		if (rst_n && rd_valid) begin
			assert (exp_data.size() > 0) else begin
				cmp_errors++;
				$display("A readout word arrived while no readout was expected.");
			end
			if (exp_data.size() > 0) begin
				want_d = exp_data.pop_front();
				want_s = exp_sat.pop_front();
				assert (rd_data == want_d) else begin
					cmp_errors++;
					$display("Fail %s word %0d data: expected %0d, actual %0d", test_name,
						word_cnt, want_d, rd_data);
				end
				assert (rd_sat == want_s) else begin
					cmp_errors++;
					$display("Fail %s word %0d sat: expected %0d, actual %0d", test_name,
						word_cnt, want_s, rd_sat);
				end
			end
			word_cnt++;
			if (rd_last) begin
				assert (word_cnt == num_words) else begin
					cmp_errors++;
					$display("Readout for %s ended after %0d words instead of %0d.", test_name,
						word_cnt, num_words);
				end
				word_cnt = 0;
				readouts_done++;
			end else begin
				assert (word_cnt < num_words) else begin
					cmp_errors++;
					$display("Readout for %s reached word %0d without rd_last.", test_name,
						word_cnt);
				end
			end
		end
	end

	initial begin
		seed          = 32'hd317;
		rst_n         = 1'b0;
		cmd_strobe    = 1'b0;
		cmd_op        = corr_ctrl_pkg::op_nop;
		cmd_line      = '0;
		cmd_arg       = '0;
		smp_strobe    = '0;
		smp_data      = '0;
		test_name     = "reset";
		word_cnt      = 0;
		readouts_done = 0;
		cmp_errors    = 0;
		ctl_errors    = 0;
		clear_model();
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		test_name = "reset_state";
		assert (running == 1'b0) else begin
			ctl_errors++;
			$display("Fail %s running: expected 0, actual %0d", test_name, running);
		end
		check_readout("reset_state", 1'b0);

		test_name = "product_offsets";
		for (int ch = 0; ch < num_inputs; ch++) begin
			set_offset(ch, ch % (max_offset + 1));
		end
		set_run(1'b1);
		drive_samples(rand_cycles, 1'b0);
		check_readout("product_offsets", 1'b1);

		test_name = "mixed_modes";
		set_mode(1, 1'b1);
		set_mode(3, 1'b1);
		drive_samples(rand_cycles, 1'b0);
		check_readout("mixed_modes", 1'b0);

		test_name = "halted";
		set_run(1'b0);
		drive_samples(short_cycles, 1'b0); // Only the delay lines move.
		check_readout("halted", 1'b0);
		clear_accumulators();
		check_readout("cleared", 1'b0);
		test_name = "rerun";
		set_run(1'b1);
		drive_samples(short_cycles, 1'b0);
		check_readout("rerun", 1'b0);

		// Channel 3 stays in difference mode and never saturates on a constant input.
		test_name = "saturation";
		set_mode(1, 1'b0);
		clear_accumulators();
		drive_samples(sat_cycles, 1'b1);
		check_readout("saturation", 1'b0);
		drive_samples(extra_cycles, 1'b1);
		check_readout("still_saturated", 1'b0);
		clear_accumulators();
		check_readout("after_clear", 1'b0);

		test_name = "bad_commands";
		send_cmd(corr_ctrl_pkg::corr_op_t'(3'd7), 0, 0, 1'b1);
		@(negedge clk);
		assert (cmd_error == 1'b0) else begin
			ctl_errors++;
			$display("cmd_error stayed high for more than one cycle.");
		end
		set_offset(2, max_offset + 1);
		drive_samples(short_cycles, 1'b0);
		check_readout("bad_commands", 1'b0);

		$display("Errors: %0d in readout words, %0d in control checks.", cmp_errors, ctl_errors);
		if (cmp_errors + ctl_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns before the tests finished.", watchdog_ns);
		$display("** FAIL **");
		$finish;
	end

endmodule
